// File: verilog/l1d_pkg.sv
// Shared widths and encodings for the L1D access block
// Defaults match the top-level parameter defaults; change both together
// Line width must be a power-of-two multiple of the walker word width

`default_nettype none

package l1d_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  parameter int unsigned PADDR_W = 16;
  parameter int unsigned XLEN_W  = 32;
  parameter int unsigned LINE_W  = 128;
  parameter int unsigned SETS    = 16;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [PADDR_W-1:0]  paddr_t;
  typedef logic [XLEN_W-1:0]   xlen_t;
  typedef logic [LINE_W-1:0]   line_t;
  // One enable per byte of a line
  typedef logic [LINE_W/8-1:0] line_be_t;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    STATUS_NONE         = 2'd0,
    STATUS_HIT          = 2'd1,
    STATUS_MISS         = 2'd2,
    STATUS_L1D_CONFLICT = 2'd3
  } access_status_t;

  typedef enum logic {
    SNOOP_READ    = 1'b0,
    SNOOP_INVALID = 1'b1
  } snoop_cmd_t;

endpackage

`default_nettype wire

// File: verilog/l1d_array.sv
// Direct-mapped L1D array with one access port per cycle
// Priority is fill, then snoop, then walker; losers see conflict one cycle later
// Tags and lines come up unknown after reset, only the valid bits are cleared
// An invalidate only clears the set when the stored tag matches

`timescale 1ns/1ps
`default_nettype none

module l1d_array #(
  parameter int unsigned PADDR_W = 16,
  parameter int unsigned LINE_W  = 128,
  parameter int unsigned SETS    = 16
) (
  input  wire logic             i_clk,
  input  wire logic             i_reset_n,
  // Fill from the miss path
  input  wire logic             i_fill_valid,
  input  wire l1d_pkg::paddr_t  i_fill_paddr,
  input  wire l1d_pkg::line_t   i_fill_data,
  // Snoop access
  input  wire logic             i_snp_rd_valid,
  input  wire logic             i_snp_inv_valid,
  input  wire l1d_pkg::paddr_t  i_snp_paddr,
  // Walker access
  input  wire logic             i_ptw_rd_valid,
  input  wire l1d_pkg::paddr_t  i_ptw_paddr,
  // Stage-1 results
  output logic                  o_snp_hit,
  output logic                  o_snp_miss,
  output logic                  o_snp_conflict,
  output l1d_pkg::line_t        o_snp_data,
  output logic                  o_ptw_hit,
  output logic                  o_ptw_miss,
  output logic                  o_ptw_conflict,
  output l1d_pkg::line_t        o_ptw_data
);

  localparam int unsigned LINE_OFF_W = $clog2(LINE_W / 8);
  localparam int unsigned SET_W      = $clog2(SETS);
  localparam int unsigned TAG_W      = PADDR_W - SET_W - LINE_OFF_W;

  typedef logic [SET_W-1:0] set_t;
  typedef logic [TAG_W-1:0] tag_t;

  logic [SETS-1:0] r_valid;
  tag_t            r_tag  [SETS];
  l1d_pkg::line_t  r_line [SETS];

  set_t w_fill_set;
  tag_t w_fill_tag;
  set_t w_rd_set;
  tag_t w_rd_tag;
  logic w_rd_hit;

  logic w_snp_req;
  logic w_snp_gnt;
  logic w_snp_rd_gnt;
  logic w_inv_gnt;
  logic w_ptw_gnt;

  logic           r_snp_hit;
  logic           r_snp_miss;
  logic           r_snp_conflict;
  logic           r_ptw_hit;
  logic           r_ptw_miss;
  logic           r_ptw_conflict;
  l1d_pkg::line_t r_rd_data;

  // ------------------------------
  // Port arbitration
  // ------------------------------
  assign w_snp_req    = i_snp_rd_valid | i_snp_inv_valid;
  assign w_snp_gnt    = w_snp_req & ~i_fill_valid;
  assign w_snp_rd_gnt = i_snp_rd_valid & w_snp_gnt;
  assign w_inv_gnt    = i_snp_inv_valid & w_snp_gnt;
  assign w_ptw_gnt    = i_ptw_rd_valid & ~i_fill_valid & ~w_snp_req;

  // Shared lookup, address taken from whichever reader owns the port
  assign w_fill_set = i_fill_paddr[LINE_OFF_W +: SET_W];
  assign w_fill_tag = i_fill_paddr[PADDR_W-1 -: TAG_W];
  assign w_rd_set   = w_snp_gnt ? i_snp_paddr[LINE_OFF_W +: SET_W] :
                                  i_ptw_paddr[LINE_OFF_W +: SET_W];
  assign w_rd_tag   = w_snp_gnt ? i_snp_paddr[PADDR_W-1 -: TAG_W] :
                                  i_ptw_paddr[PADDR_W-1 -: TAG_W];
  assign w_rd_hit   = r_valid[w_rd_set] & (r_tag[w_rd_set] == w_rd_tag);

  // ------------------------------
  // Array update
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_fill_valid) begin
      r_valid[w_fill_set] <= 1'b1;
    end else if (w_inv_gnt && w_rd_hit) begin
      r_valid[w_rd_set] <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_tag[w_fill_set]  <= w_fill_tag;
      r_line[w_fill_set] <= i_fill_data;
    end
  end

  // ------------------------------
  // Stage-1 result registers
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_snp_hit      <= 1'b0;
      r_snp_miss     <= 1'b0;
      r_snp_conflict <= 1'b0;
      r_ptw_hit      <= 1'b0;
      r_ptw_miss     <= 1'b0;
      r_ptw_conflict <= 1'b0;
    end else begin
      r_snp_hit      <= w_snp_rd_gnt & w_rd_hit;
      r_snp_miss     <= w_snp_rd_gnt & ~w_rd_hit;
      // Covers a lost read and a lost invalidate alike
      r_snp_conflict <= w_snp_req & i_fill_valid;
      r_ptw_hit      <= w_ptw_gnt & w_rd_hit;
      r_ptw_miss     <= w_ptw_gnt & ~w_rd_hit;
      r_ptw_conflict <= i_ptw_rd_valid & ~w_ptw_gnt;
    end
  end

  // One read per cycle, so both readers share the data register
  always_ff @(posedge i_clk) begin
    r_rd_data <= r_line[w_rd_set];
  end

  assign o_snp_hit      = r_snp_hit;
  assign o_snp_miss     = r_snp_miss;
  assign o_snp_conflict = r_snp_conflict;
  assign o_snp_data     = r_rd_data;
  assign o_ptw_hit      = r_ptw_hit;
  assign o_ptw_miss     = r_ptw_miss;
  assign o_ptw_conflict = r_ptw_conflict;
  assign o_ptw_data     = r_rd_data;

endmodule

`default_nettype wire

// File: verilog/ptw_access_port.sv
// Walker access port, one request per cycle, response one cycle later
// No back-pressure; the walker must take every response
// Line width must be a power-of-two multiple of the word width

`timescale 1ns/1ps
`default_nettype none

module ptw_access_port #(
  parameter int unsigned PADDR_W = 16,
  parameter int unsigned XLEN_W  = 32,
  parameter int unsigned LINE_W  = 128
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire logic                    i_req_valid,
  input  wire l1d_pkg::paddr_t         i_paddr,
  output logic                         o_rd_valid,
  output l1d_pkg::paddr_t              o_rd_paddr,
  input  wire logic                    i_s1_hit,
  input  wire logic                    i_s1_miss,
  input  wire logic                    i_s1_conflict,
  input  wire l1d_pkg::line_t          i_s1_data,
  output logic                         o_resp_valid,
  output l1d_pkg::access_status_t      o_status,
  output l1d_pkg::xlen_t               o_data
);

  localparam int unsigned WORD_OFF_W = $clog2(XLEN_W / 8);
  localparam int unsigned SEL_W      = $clog2(LINE_W / XLEN_W);

  logic r_resp_valid;

  // Walker reads whole words, so the byte offset is dropped
  assign o_rd_valid = i_req_valid;
  assign o_rd_paddr = {i_paddr[PADDR_W-1:WORD_OFF_W], {WORD_OFF_W{1'b0}}};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_req_valid;
    end
  end

  assign o_resp_valid = r_resp_valid;
  assign o_status = i_s1_conflict ? l1d_pkg::STATUS_L1D_CONFLICT :
                    i_s1_hit      ? l1d_pkg::STATUS_HIT :
                    i_s1_miss     ? l1d_pkg::STATUS_MISS :
                                    l1d_pkg::STATUS_NONE;

  // ------------------------------
  // Word select
  // ------------------------------
  if (LINE_W == XLEN_W) begin : g_one_word
    assign o_data = i_s1_data;
  end else begin : g_word_sel
    logic [SEL_W-1:0] r_word_sel;

    always_ff @(posedge i_clk) begin
      r_word_sel <= i_paddr[WORD_OFF_W +: SEL_W];
    end

    assign o_data = i_s1_data[r_word_sel*XLEN_W +: XLEN_W];
  end

endmodule

`default_nettype wire

// File: verilog/snoop_port.sv
// Snoop port, read or invalidate one line, response one cycle later
// Snoop addresses are line granular, the offset is cleared
// Byte enables are all set on a hit and zero otherwise

`timescale 1ns/1ps
`default_nettype none

module snoop_port #(
  parameter int unsigned PADDR_W = 16
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire logic                    i_req_valid,
  input  wire l1d_pkg::snoop_cmd_t     i_cmd,
  input  wire l1d_pkg::paddr_t         i_paddr,
  output logic                         o_rd_valid,
  output logic                         o_inv_valid,
  output l1d_pkg::paddr_t              o_paddr,
  input  wire logic                    i_s1_hit,
  input  wire logic                    i_s1_miss,
  input  wire logic                    i_s1_conflict,
  input  wire l1d_pkg::line_t          i_s1_data,
  output logic                         o_resp_valid,
  output l1d_pkg::access_status_t      o_status,
  output l1d_pkg::line_t               o_data,
  output l1d_pkg::line_be_t            o_be
);

  localparam int unsigned LINE_OFF_W = $clog2($bits(l1d_pkg::line_be_t));

  logic r_resp_valid;

  // ------------------------------
  // Command decode
  // ------------------------------
  assign o_rd_valid  = i_req_valid & (i_cmd == l1d_pkg::SNOOP_READ);
  assign o_inv_valid = i_req_valid & (i_cmd == l1d_pkg::SNOOP_INVALID);
  assign o_paddr     = {i_paddr[PADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_req_valid;
    end
  end

  // ------------------------------
  // Response
  // ------------------------------
  assign o_resp_valid = r_resp_valid;
  // Granted invalidate reports no flag at all and falls through to none
  assign o_status = i_s1_conflict ? l1d_pkg::STATUS_L1D_CONFLICT :
                    i_s1_hit      ? l1d_pkg::STATUS_HIT :
                    i_s1_miss     ? l1d_pkg::STATUS_MISS :
                                    l1d_pkg::STATUS_NONE;
  assign o_data   = i_s1_data;
  assign o_be     = i_s1_hit ? '1 : '0;

endmodule

`default_nettype wire

// File: verilog/l1d_access_top.sv
// L1D access block for walker reads, snoops and line fills
// Every request gets exactly one response one cycle later, no back-pressure
// Parameters must agree with the package widths

`timescale 1ns/1ps
`default_nettype none

module l1d_access_top #(
  parameter int unsigned PADDR_W = l1d_pkg::PADDR_W,
  parameter int unsigned XLEN_W  = l1d_pkg::XLEN_W,
  parameter int unsigned LINE_W  = l1d_pkg::LINE_W,
  parameter int unsigned SETS    = l1d_pkg::SETS
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  // Walker
  input  wire logic                    i_ptw_req_valid,
  input  wire l1d_pkg::paddr_t         i_ptw_paddr,
  output logic                         o_ptw_resp_valid,
  output l1d_pkg::access_status_t      o_ptw_status,
  output l1d_pkg::xlen_t               o_ptw_data,
  // Snoop
  input  wire logic                    i_snoop_req_valid,
  input  wire l1d_pkg::snoop_cmd_t     i_snoop_cmd,
  input  wire l1d_pkg::paddr_t         i_snoop_paddr,
  output logic                         o_snoop_resp_valid,
  output l1d_pkg::access_status_t      o_snoop_status,
  output l1d_pkg::line_t               o_snoop_data,
  output l1d_pkg::line_be_t            o_snoop_be,
  // Fill
  input  wire logic                    i_fill_valid,
  input  wire l1d_pkg::paddr_t         i_fill_paddr,
  input  wire l1d_pkg::line_t          i_fill_data
);

  logic            w_ptw_rd_valid;
  l1d_pkg::paddr_t w_ptw_rd_paddr;
  logic            w_ptw_s1_hit;
  logic            w_ptw_s1_miss;
  logic            w_ptw_s1_conflict;
  l1d_pkg::line_t  w_ptw_s1_data;

  logic            w_snp_rd_valid;
  logic            w_snp_inv_valid;
  l1d_pkg::paddr_t w_snp_paddr;
  logic            w_snp_s1_hit;
  logic            w_snp_s1_miss;
  logic            w_snp_s1_conflict;
  l1d_pkg::line_t  w_snp_s1_data;

  // ------------------------------
  // Walker port
  // ------------------------------
  ptw_access_port #(
    .PADDR_W (PADDR_W),
    .XLEN_W  (XLEN_W),
    .LINE_W  (LINE_W)
  ) u_ptw_port (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_ptw_req_valid),
    .i_paddr       (i_ptw_paddr),
    .o_rd_valid    (w_ptw_rd_valid),
    .o_rd_paddr    (w_ptw_rd_paddr),
    .i_s1_hit      (w_ptw_s1_hit),
    .i_s1_miss     (w_ptw_s1_miss),
    .i_s1_conflict (w_ptw_s1_conflict),
    .i_s1_data     (w_ptw_s1_data),
    .o_resp_valid  (o_ptw_resp_valid),
    .o_status      (o_ptw_status),
    .o_data        (o_ptw_data)
  );

  // ------------------------------
  // Snoop port
  // ------------------------------
  snoop_port #(
    .PADDR_W (PADDR_W)
  ) u_snoop_port (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_valid   (i_snoop_req_valid),
    .i_cmd         (i_snoop_cmd),
    .i_paddr       (i_snoop_paddr),
    .o_rd_valid    (w_snp_rd_valid),
    .o_inv_valid   (w_snp_inv_valid),
    .o_paddr       (w_snp_paddr),
    .i_s1_hit      (w_snp_s1_hit),
    .i_s1_miss     (w_snp_s1_miss),
    .i_s1_conflict (w_snp_s1_conflict),
    .i_s1_data     (w_snp_s1_data),
    .o_resp_valid  (o_snoop_resp_valid),
    .o_status      (o_snoop_status),
    .o_data        (o_snoop_data),
    .o_be          (o_snoop_be)
  );

  // ------------------------------
  // Array
  // ------------------------------
  l1d_array #(
    .PADDR_W (PADDR_W),
    .LINE_W  (LINE_W),
    .SETS    (SETS)
  ) u_array (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_fill_valid    (i_fill_valid),
    .i_fill_paddr    (i_fill_paddr),
    .i_fill_data     (i_fill_data),
    .i_snp_rd_valid  (w_snp_rd_valid),
    .i_snp_inv_valid (w_snp_inv_valid),
    .i_snp_paddr     (w_snp_paddr),
    .i_ptw_rd_valid  (w_ptw_rd_valid),
    .i_ptw_paddr     (w_ptw_rd_paddr),
    .o_snp_hit       (w_snp_s1_hit),
    .o_snp_miss      (w_snp_s1_miss),
    .o_snp_conflict  (w_snp_s1_conflict),
    .o_snp_data      (w_snp_s1_data),
    .o_ptw_hit       (w_ptw_s1_hit),
    .o_ptw_miss      (w_ptw_s1_miss),
    .o_ptw_conflict  (w_ptw_s1_conflict),
    .o_ptw_data      (w_ptw_s1_data)
  );

endmodule

`default_nettype wire

// File: tests/l1d_checker.sv
// Response timing assertions for l1d_access_top
// Checks are off while reset is asserted

`timescale 1ns/1ps
`default_nettype none

module l1d_checker (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire logic                    i_ptw_req_valid,
  input  wire logic                    i_ptw_resp_valid,
  input  wire logic                    i_snoop_req_valid,
  input  wire logic                    i_snoop_resp_valid,
  input  wire l1d_pkg::access_status_t i_snoop_status,
  input  wire l1d_pkg::line_be_t       i_snoop_be
);

  int fail_count = 0;

  // ------------------------------
  // One response per request in the next cycle
  // ------------------------------
  ptw_resp_follows_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_req_valid |=> i_ptw_resp_valid)
  else begin
    $error("Walker request not answered in the next cycle");
    fail_count += 1;
  end

  snoop_resp_follows_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_req_valid |=> i_snoop_resp_valid)
  else begin
    $error("Snoop request not answered in the next cycle");
    fail_count += 1;
  end

  // No response without a request in the cycle before
  ptw_resp_has_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_resp_valid |-> $past(i_ptw_req_valid))
  else begin
    $error("Walker response without a request");
    fail_count += 1;
  end

  snoop_resp_has_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_resp_valid |-> $past(i_snoop_req_valid))
  else begin
    $error("Snoop response without a request");
    fail_count += 1;
  end

  // Full byte enables exactly on a snoop hit
  snoop_be_on_hit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_resp_valid |->
      ((i_snoop_be == '1) == (i_snoop_status == l1d_pkg::STATUS_HIT)))
  else begin
    $error("Snoop byte enables disagree with the hit status");
    fail_count += 1;
  end

endmodule

bind l1d_access_top l1d_checker u_checker (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_ptw_req_valid    (i_ptw_req_valid),
  .i_ptw_resp_valid   (o_ptw_resp_valid),
  .i_snoop_req_valid  (i_snoop_req_valid),
  .i_snoop_resp_valid (o_snoop_resp_valid),
  .i_snoop_status     (o_snoop_status),
  .i_snoop_be         (o_snoop_be)
);

`default_nettype wire

// File: tests/tb_monitor.sv
// Reference model and response checker for the L1D access block
// Inputs and outputs are sampled on the falling edge, where both are stable
// Data is compared only on a hit, miss and conflict data are don't-care

`timescale 1ns/1ps
`default_nettype none

module tb_monitor (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire logic                    i_ptw_req_valid,
  input  wire l1d_pkg::paddr_t         i_ptw_paddr,
  input  wire logic                    i_ptw_resp_valid,
  input  wire l1d_pkg::access_status_t i_ptw_status,
  input  wire l1d_pkg::xlen_t          i_ptw_data,
  input  wire logic                    i_snoop_req_valid,
  input  wire l1d_pkg::snoop_cmd_t     i_snoop_cmd,
  input  wire l1d_pkg::paddr_t         i_snoop_paddr,
  input  wire logic                    i_snoop_resp_valid,
  input  wire l1d_pkg::access_status_t i_snoop_status,
  input  wire l1d_pkg::line_t          i_snoop_data,
  input  wire l1d_pkg::line_be_t       i_snoop_be,
  input  wire logic                    i_fill_valid,
  input  wire l1d_pkg::paddr_t         i_fill_paddr,
  input  wire l1d_pkg::line_t          i_fill_data,
  output int                           o_error_count
);

  localparam int unsigned LINE_OFF_W = $clog2(l1d_pkg::LINE_W / 8);
  localparam int unsigned SET_W      = $clog2(l1d_pkg::SETS);
  localparam int unsigned TAG_W      = l1d_pkg::PADDR_W - SET_W - LINE_OFF_W;
  localparam int unsigned WORD_OFF_W = $clog2(l1d_pkg::XLEN_W / 8);
  localparam int unsigned SEL_W      = $clog2(l1d_pkg::LINE_W / l1d_pkg::XLEN_W);

  typedef logic [SET_W-1:0] set_t;
  typedef logic [TAG_W-1:0] tag_t;

  // Reference copy of the array
  logic [l1d_pkg::SETS-1:0] m_valid = '0;
  tag_t                     m_tag  [l1d_pkg::SETS];
  l1d_pkg::line_t           m_line [l1d_pkg::SETS];

  // Responses expected in the next cycle
  logic                     exp_ptw_valid = 1'b0;
  l1d_pkg::access_status_t  exp_ptw_status;
  l1d_pkg::xlen_t           exp_ptw_data;
  logic                     exp_snp_valid = 1'b0;
  l1d_pkg::access_status_t  exp_snp_status;
  l1d_pkg::line_t           exp_snp_data;

  logic snp_gnt;
  logic ptw_gnt;
  logic snp_inv;
  int   errors = 0;

  assign o_error_count = errors;

  // ------------------------------
  // Reference functions
  // ------------------------------
  function automatic set_t set_of(input l1d_pkg::paddr_t addr);
    return addr[LINE_OFF_W +: SET_W];
  endfunction

  function automatic logic line_present(input l1d_pkg::paddr_t addr);
    return m_valid[set_of(addr)] &&
           (m_tag[set_of(addr)] == addr[l1d_pkg::PADDR_W-1 -: TAG_W]);
  endfunction

  // Lost requests first, then invalidate, then the lookup
  function automatic l1d_pkg::access_status_t predict_status(
    input logic            granted,
    input logic            is_inv,
    input l1d_pkg::paddr_t addr
  );
    return !granted           ? l1d_pkg::STATUS_L1D_CONFLICT :
           is_inv             ? l1d_pkg::STATUS_NONE :
           line_present(addr) ? l1d_pkg::STATUS_HIT :
                                l1d_pkg::STATUS_MISS;
  endfunction

  function automatic l1d_pkg::xlen_t predict_word(input l1d_pkg::paddr_t addr);
    logic [SEL_W-1:0] sel;
    sel = addr[WORD_OFF_W +: SEL_W];
    return m_line[set_of(addr)][int'(sel) * l1d_pkg::XLEN_W +: l1d_pkg::XLEN_W];
  endfunction

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic report_value(input string name, input string exp_s, input string act_s);
    $display("FAIL time=%0t signal=%s expected=%s actual=%s", $time, name, exp_s, act_s);
    errors += 1;
  endtask

  task automatic report_event(input string what);
    $display("ERROR time=%0t %s", $time, what);
    errors += 1;
  endtask

  task automatic check_responses();
    l1d_pkg::line_be_t exp_be;
    exp_be = (exp_snp_status == l1d_pkg::STATUS_HIT) ? '1 : '0;
    if (i_ptw_resp_valid !== exp_ptw_valid) begin
      if (exp_ptw_valid) begin
        report_event("walker request got no response");
      end else begin
        report_event("walker response appeared without a request");
      end
    end else if (exp_ptw_valid) begin
      if (i_ptw_status !== exp_ptw_status) begin
        report_value("o_ptw_status", $sformatf("%0d", exp_ptw_status),
                     $sformatf("%0d", i_ptw_status));
      end else if (exp_ptw_status == l1d_pkg::STATUS_HIT && i_ptw_data !== exp_ptw_data) begin
        report_value("o_ptw_data", $sformatf("%h", exp_ptw_data), $sformatf("%h", i_ptw_data));
      end
    end
    if (i_snoop_resp_valid !== exp_snp_valid) begin
      if (exp_snp_valid) begin
        report_event("snoop request got no response");
      end else begin
        report_event("snoop response appeared without a request");
      end
    end else if (exp_snp_valid) begin
      if (i_snoop_status !== exp_snp_status) begin
        report_value("o_snoop_status", $sformatf("%0d", exp_snp_status),
                     $sformatf("%0d", i_snoop_status));
      end
      if (i_snoop_be !== exp_be) begin
        report_value("o_snoop_be", $sformatf("%h", exp_be), $sformatf("%h", i_snoop_be));
      end
      if (exp_snp_status == l1d_pkg::STATUS_HIT && i_snoop_data !== exp_snp_data) begin
        report_value("o_snoop_data", $sformatf("%h", exp_snp_data),
                     $sformatf("%h", i_snoop_data));
      end
    end
  endtask

  // ------------------------------
  // Compare, then predict the next cycle
  // ------------------------------
  always @(negedge i_clk) begin
    check_responses();
    if (!i_reset_n) begin
      m_valid       = '0;
      exp_ptw_valid = 1'b0;
      exp_snp_valid = 1'b0;
    end else begin
      snp_gnt = i_snoop_req_valid && !i_fill_valid;
      ptw_gnt = i_ptw_req_valid && !i_fill_valid && !i_snoop_req_valid;
      snp_inv = (i_snoop_cmd == l1d_pkg::SNOOP_INVALID);

      exp_ptw_valid  = i_ptw_req_valid;
      exp_ptw_status = predict_status(ptw_gnt, 1'b0, i_ptw_paddr);
      exp_ptw_data   = predict_word(i_ptw_paddr);
      exp_snp_valid  = i_snoop_req_valid;
      exp_snp_status = predict_status(snp_gnt, snp_inv, i_snoop_paddr);
      exp_snp_data   = m_line[set_of(i_snoop_paddr)];

      // Writes land after this cycle's lookups
      if (i_fill_valid) begin
        m_valid[set_of(i_fill_paddr)] = 1'b1;
        m_tag[set_of(i_fill_paddr)]   = i_fill_paddr[l1d_pkg::PADDR_W-1 -: TAG_W];
        m_line[set_of(i_fill_paddr)]  = i_fill_data;
      end else if (snp_gnt && snp_inv && line_present(i_snoop_paddr)) begin
        m_valid[set_of(i_snoop_paddr)] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
// Testbench top for the L1D access block
// Directed cases first, then random traffic over sets 0 to 3 and two tags
// Expected values come from tb_monitor
// This module drives the stimulus and prints the results

`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int unsigned TEST_CYCLES = 300;
  localparam int unsigned MAX_CYCLES  = TEST_CYCLES * 2;
  localparam int unsigned RAND_CYCLES = 200;

  logic                    clk;
  logic                    reset_n;
  logic                    ptw_req_valid;
  l1d_pkg::paddr_t         ptw_paddr;
  logic                    ptw_resp_valid;
  l1d_pkg::access_status_t ptw_status;
  l1d_pkg::xlen_t          ptw_data;
  logic                    snoop_req_valid;
  l1d_pkg::snoop_cmd_t     snoop_cmd;
  l1d_pkg::paddr_t         snoop_paddr;
  logic                    snoop_resp_valid;
  l1d_pkg::access_status_t snoop_status;
  l1d_pkg::line_t          snoop_data;
  l1d_pkg::line_be_t       snoop_be;
  logic                    fill_valid;
  l1d_pkg::paddr_t         fill_paddr;
  l1d_pkg::line_t          fill_data;

  int          mon_errors;
  int          errors_seen;
  int          tests_run;
  int          tests_failed;
  int          cycle_count = 0;
  logic [31:0] seed;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // DUT and monitor
  // ------------------------------
  l1d_access_top i_dut (
    .i_clk              (clk),
    .i_reset_n          (reset_n),
    .i_ptw_req_valid    (ptw_req_valid),
    .i_ptw_paddr        (ptw_paddr),
    .o_ptw_resp_valid   (ptw_resp_valid),
    .o_ptw_status       (ptw_status),
    .o_ptw_data         (ptw_data),
    .i_snoop_req_valid  (snoop_req_valid),
    .i_snoop_cmd        (snoop_cmd),
    .i_snoop_paddr      (snoop_paddr),
    .o_snoop_resp_valid (snoop_resp_valid),
    .o_snoop_status     (snoop_status),
    .o_snoop_data       (snoop_data),
    .o_snoop_be         (snoop_be),
    .i_fill_valid       (fill_valid),
    .i_fill_paddr       (fill_paddr),
    .i_fill_data        (fill_data)
  );

  tb_monitor u_monitor (
    .i_clk              (clk),
    .i_reset_n          (reset_n),
    .i_ptw_req_valid    (ptw_req_valid),
    .i_ptw_paddr        (ptw_paddr),
    .i_ptw_resp_valid   (ptw_resp_valid),
    .i_ptw_status       (ptw_status),
    .i_ptw_data         (ptw_data),
    .i_snoop_req_valid  (snoop_req_valid),
    .i_snoop_cmd        (snoop_cmd),
    .i_snoop_paddr      (snoop_paddr),
    .i_snoop_resp_valid (snoop_resp_valid),
    .i_snoop_status     (snoop_status),
    .i_snoop_data       (snoop_data),
    .i_snoop_be         (snoop_be),
    .i_fill_valid       (fill_valid),
    .i_fill_paddr       (fill_paddr),
    .i_fill_data        (fill_data),
    .o_error_count      (mon_errors)
  );

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Tag 0 or 1, set 0 to 3, any offset
  // Only upper bits are used since the low LCG bits have short periods
  function automatic l1d_pkg::paddr_t rand_paddr(input logic [31:0] r);
    return {7'd0, r[31], 2'b00, r[30:29], r[28:25]};
  endfunction

  task automatic issue(
    input logic                f_v,
    input l1d_pkg::paddr_t     f_a,
    input l1d_pkg::line_t      f_d,
    input logic                s_v,
    input l1d_pkg::snoop_cmd_t s_c,
    input l1d_pkg::paddr_t     s_a,
    input logic                p_v,
    input l1d_pkg::paddr_t     p_a
  );
    @(posedge clk);
    fill_valid      <= f_v;
    fill_paddr      <= f_a;
    fill_data       <= f_d;
    snoop_req_valid <= s_v;
    snoop_cmd       <= s_c;
    snoop_paddr     <= s_a;
    ptw_req_valid   <= p_v;
    ptw_paddr       <= p_a;
  endtask

  task automatic idle_cycle();
    issue(1'b0, '0, '0, 1'b0, l1d_pkg::SNOOP_READ, '0, 1'b0, '0);
  endtask

  task automatic fill_line(input l1d_pkg::paddr_t a, input l1d_pkg::line_t d);
    issue(1'b1, a, d, 1'b0, l1d_pkg::SNOOP_READ, '0, 1'b0, '0);
  endtask

  task automatic snoop_req(input l1d_pkg::snoop_cmd_t c, input l1d_pkg::paddr_t a);
    issue(1'b0, '0, '0, 1'b1, c, a, 1'b0, '0);
  endtask

  task automatic walker_read(input l1d_pkg::paddr_t a);
    issue(1'b0, '0, '0, 1'b0, l1d_pkg::SNOOP_READ, '0, 1'b1, a);
  endtask

  task automatic random_cycle();
    logic [31:0]         r;
    l1d_pkg::paddr_t     fa;
    l1d_pkg::line_t      fd;
    l1d_pkg::paddr_t     sa;
    l1d_pkg::paddr_t     pa;
    l1d_pkg::snoop_cmd_t cmd;
    r   = next_rand();
    fa  = rand_paddr(next_rand());
    fd  = {next_rand(), next_rand(), next_rand(), next_rand()};
    sa  = rand_paddr(next_rand());
    pa  = rand_paddr(next_rand());
    cmd = (r[27:26] == 2'b11) ? l1d_pkg::SNOOP_INVALID : l1d_pkg::SNOOP_READ;
    issue(r[31:30] == 2'b00, fa, fd, r[29], cmd, sa, r[28], pa);
  endtask

  // Three idle cycles let the monitor and the checker see the last response
  task automatic finish_test(input string name);
    int total;
    int new_errors;
    idle_cycle();
    idle_cycle();
    idle_cycle();
    total       = mon_errors + i_dut.u_checker.fail_count;
    new_errors  = total - errors_seen;
    errors_seen = total;
    tests_run  += 1;
    if (new_errors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, new_errors);
      tests_failed += 1;
    end
  endtask

  // ------------------------------
  // Timeout
  // ------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    reset_n         = 1'b0;
    fill_valid      = 1'b0;
    fill_paddr      = '0;
    fill_data       = '0;
    snoop_req_valid = 1'b0;
    snoop_cmd       = l1d_pkg::SNOOP_READ;
    snoop_paddr     = '0;
    ptw_req_valid   = 1'b0;
    ptw_paddr       = '0;
    seed            = 32'h74a0_cb43;
    errors_seen     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    walker_read(16'h0000);
    walker_read(16'h1234);
    walker_read(16'hfff8);
    finish_test("reset_walker_miss");

    fill_line(16'h0150, 128'h3333_cccc_2222_dddd_1111_eeee_0000_ffff);
    walker_read(16'h0150);
    walker_read(16'h0154);
    walker_read(16'h0158);
    walker_read(16'h015c);
    finish_test("fill_walker_words");

    snoop_req(l1d_pkg::SNOOP_READ, 16'h0150);
    snoop_req(l1d_pkg::SNOOP_READ, 16'h0260);
    finish_test("snoop_read");

    // Snoop beats walker and fill beats both
    issue(1'b0, '0, '0, 1'b1, l1d_pkg::SNOOP_READ, 16'h0150, 1'b1, 16'h0154);
    issue(1'b1, 16'h0290, {4{32'h0bad_f00d}}, 1'b1, l1d_pkg::SNOOP_READ, 16'h0150,
          1'b0, '0);
    issue(1'b1, 16'h02a0, {4{32'h1357_9bdf}}, 1'b0, l1d_pkg::SNOOP_READ, '0,
          1'b1, 16'h0150);
    finish_test("port_conflicts");

    snoop_req(l1d_pkg::SNOOP_INVALID, 16'h0150);
    walker_read(16'h0150);
    fill_line(16'h0370, {4{32'h7777_0370}});
    issue(1'b1, 16'h0480, {4{32'h8888_0480}}, 1'b1, l1d_pkg::SNOOP_INVALID, 16'h0370,
          1'b0, '0);
    walker_read(16'h0378);
    finish_test("snoop_invalidate");

    for (int i = 0; i < RAND_CYCLES; i++) begin
      random_cycle();
    end
    finish_test("random_mixed");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors_seen);
    if (tests_failed == 0 && errors_seen == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/l1d_pkg.sv
verilog/l1d_array.sv
verilog/ptw_access_port.sv
verilog/snoop_port.sv
verilog/l1d_access_top.sv
tests/l1d_checker.sv
tests/tb_monitor.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run of the L1D access testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f files.f -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
